//--- common/ssc_pkg.sv
/*
 * shared widths and constants for the snack calculator
 * card word union, order, priced and result structs
 */

package ssc_pkg;

    // ====================
    // sizes
    // ====================

    // snack kinds per order
    localparam int n_items = 8;
    // BCD digits in a card number
    localparam int n_digits = 16;

    // Luhn acceptance window, inclusive
    localparam logic [7:0] luhn_min = 8'd50;
    localparam logic [7:0] luhn_max = 8'd120;

    // ====================
    // basic types
    // ====================

    typedef logic [3:0] digit_t;

    // one Luhn pair, doubled digit in the upper nibble
    typedef struct packed {
        digit_t dbl;
        digit_t plain;
    } digit_pair_t;

    // card word, read as plain digits or as doubled/plain pairs
    // digits[n_digits-1] is the most significant digit
    typedef union packed {
        digit_t      [n_digits-1:0]   digits;
        digit_pair_t [n_digits/2-1:0] pairs;
    } card_u;

    // counts and prices, one nibble per snack
    typedef logic [n_items-1:0][3:0] nibble_vec_t;

    // count * price, 15 * 15 fits in 8 bits
    typedef logic [7:0] cost_t;
    typedef cost_t [n_items-1:0] cost_vec_t;

    typedef logic [8:0] money_t;

    // ====================
    // stage payloads
    // ====================

    typedef struct packed {
        card_u       card;
        money_t      money;
        nibble_vec_t counts;
        nibble_vec_t prices;
    } order_t;

    // after stage 1 (costs unsorted) and stage 2 (costs[0] is largest)
    typedef struct packed {
        logic      card_ok;
        money_t    money;
        cost_vec_t costs;
    } priced_t;

    typedef struct packed {
        logic   card_ok;
        money_t change;
    } result_t;

endpackage

//--- verilog/card_checker.sv
/*
 * Luhn check of a 16-digit BCD card number
 * digit doubling, digit sum and acceptance window
 */

`timescale 1ns/1ns

module card_checker (
    input  ssc_pkg::card_u card,
    output logic           card_ok
);

    import ssc_pkg::*;

    // doubled digit after the minus-9 fold stays 0..9 for legal BCD
    logic [4:0] dbl_fold [n_digits/2];
    // fold plus plain digit per pair is at most 18
    logic [4:0] pair_sum [n_digits/2];
    // sum over all sixteen digits is at most 144
    logic [7:0] luhn_sum;
    logic       in_window;
    logic       mult_of_ten;

    // ====================
    // digit mapping
    // ====================

    always_comb begin
        logic [4:0] dbl_x2;
        for (int i = 0; i < n_digits/2; i++) begin
            dbl_x2 = {card.pairs[i].dbl, 1'b0};
            // 10..18 fold to 1..9
            if (dbl_x2 >= 5'd10)
                dbl_fold[i] = dbl_x2 - 5'd9;
            else
                dbl_fold[i] = dbl_x2;
            pair_sum[i] = dbl_fold[i] + {1'b0, card.pairs[i].plain};
        end
    end

    // ====================
    // digit sum and verdict
    // ====================

    always_comb begin
        luhn_sum = 8'd0;
        // pairwise sums first, then a running total
        for (int i = n_digits/2 - 1; i >= 0; i--)
            luhn_sum = luhn_sum + {3'd0, pair_sum[i]};
    end

    assign in_window   = (luhn_sum >= luhn_min) && (luhn_sum <= luhn_max);
    assign mult_of_ten = (luhn_sum % 8'd10) == 8'd0;

    // both conditions needed
    assign card_ok = in_window && mult_of_ten;

endmodule

//--- verilog/snack_cost.sv
/*
 * eight 4x4 shift-add multipliers
 * cost of each snack is count times unit price
 */

`timescale 1ns/1ns

module snack_cost (
    input  ssc_pkg::nibble_vec_t counts,
    input  ssc_pkg::nibble_vec_t prices,
    output ssc_pkg::cost_vec_t   costs
);

    import ssc_pkg::*;

    // one multiplier per snack slot
    for (genvar i = 0; i < n_items; i++) begin : g_mul
        // partial products, one per price bit
        logic [3:0] pp0;
        logic [4:0] pp1;
        logic [5:0] pp2;
        logic [6:0] pp3;
        // first adder level
        logic [7:0] lo_sum;
        logic [7:0] hi_sum;

        // count shifted by the price bit position
        assign pp0 = prices[i][0] ? counts[i] : 4'd0;
        assign pp1 = prices[i][1] ? {counts[i], 1'b0} : 5'd0;
        assign pp2 = prices[i][2] ? {counts[i], 2'b00} : 6'd0;
        assign pp3 = prices[i][3] ? {counts[i], 3'b000} : 7'd0;

        // two-level tree
        // bits 0,1 and bits 2,3 in parallel
        assign lo_sum = {4'd0, pp0} + {3'd0, pp1};
        assign hi_sum = {2'd0, pp2} + {1'b0, pp3};

        // final add, no overflow past 8 bits since 15*15 = 225
        assign costs[i] = lo_sum + hi_sum;
    end

endmodule

//--- verilog/order_eval.sv
/*
 * pipeline stage 1
 * card verdict and unsorted snack costs in one valid/ready slot
 */

`timescale 1ns/1ns

module order_eval (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  ssc_pkg::order_t  in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output ssc_pkg::priced_t out_data
);

    import ssc_pkg::*;

    logic      card_ok;
    cost_vec_t costs;
    priced_t   next_data;

    // ====================
    // combinational work
    // ====================

    card_checker i_card_checker (
        .card    (in_data.card),
        .card_ok (card_ok)
    );

    snack_cost i_snack_cost (
        .counts (in_data.counts),
        .prices (in_data.prices),
        .costs  (costs)
    );

    always_comb begin
        next_data.card_ok = card_ok;
        next_data.money   = in_data.money;
        next_data.costs   = costs;
    end

    // ====================
    // slot
    // ====================

    // free when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

//--- sort/sort_network.sv
/*
 * pipeline stage 2
 * 19-comparator network, eight costs into descending order, registered
 */

`timescale 1ns/1ns

module sort_network (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  ssc_pkg::priced_t in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output ssc_pkg::priced_t out_data
);

    import ssc_pkg::*;

    // outputs of each comparator layer
    cost_vec_t lyr_a;
    cost_vec_t lyr_b;
    cost_vec_t lyr_c;
    cost_vec_t lyr_d;
    cost_vec_t lyr_e;
    cost_vec_t lyr_f;
    priced_t   next_data;

    // compare-exchange
    // larger value ends up at the lower index
    function automatic cost_vec_t cmp_swap(
        input cost_vec_t v,
        input int        hi,
        input int        lo
    );
        cost_vec_t r;
        r = v;
        if (v[lo] > v[hi]) begin
            r[hi] = v[lo];
            r[lo] = v[hi];
        end
        return r;
    endfunction

    // ====================
    // comparator layers
    // ====================

    always_comb begin
        // stride 2 inside each half
        lyr_a = cmp_swap(in_data.costs, 0, 2);
        lyr_a = cmp_swap(lyr_a, 1, 3);
        lyr_a = cmp_swap(lyr_a, 4, 6);
        lyr_a = cmp_swap(lyr_a, 5, 7);

        // across halves
        lyr_b = cmp_swap(lyr_a, 0, 4);
        lyr_b = cmp_swap(lyr_b, 1, 5);
        lyr_b = cmp_swap(lyr_b, 2, 6);
        lyr_b = cmp_swap(lyr_b, 3, 7);

        // neighbours, fixes the two ends
        lyr_c = cmp_swap(lyr_b, 0, 1);
        lyr_c = cmp_swap(lyr_c, 2, 3);
        lyr_c = cmp_swap(lyr_c, 4, 5);
        lyr_c = cmp_swap(lyr_c, 6, 7);

        // middle merge
        lyr_d = cmp_swap(lyr_c, 2, 4);
        lyr_d = cmp_swap(lyr_d, 3, 5);

        lyr_e = cmp_swap(lyr_d, 1, 4);
        lyr_e = cmp_swap(lyr_e, 3, 6);

        // last clean-up of the inner six
        lyr_f = cmp_swap(lyr_e, 1, 2);
        lyr_f = cmp_swap(lyr_f, 3, 4);
        lyr_f = cmp_swap(lyr_f, 5, 6);
    end

    always_comb begin
        next_data.card_ok = in_data.card_ok;
        next_data.money   = in_data.money;
        next_data.costs   = lyr_f;
    end

    // ====================
    // slot
    // ====================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

//--- verilog/change_calc.sv
/*
 * pipeline stage 3
 * greedy purchase over sorted costs, change held in the output slot
 */

`timescale 1ns/1ns

module change_calc (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  ssc_pkg::priced_t in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output ssc_pkg::result_t out_data
);

    import ssc_pkg::*;

    // money left after buying snacks 0..i
    money_t  rem [n_items];
    money_t  change;
    result_t next_data;

    // ====================
    // remainder chain
    // ====================

    always_comb begin
        rem[0] = in_data.money - {1'b0, in_data.costs[0]};
        for (int i = 1; i < n_items; i++)
            rem[i] = rem[i-1] - {1'b0, in_data.costs[i]};
    end

    // ====================
    // pick the stop point
    // ====================

    // walk from the end down, so the earliest short remainder wins
    // remainders past that point may have wrapped and are never picked
    always_comb begin
        change = rem[n_items-1];
        for (int i = n_items - 2; i >= 0; i--) begin
            if (rem[i] < {1'b0, in_data.costs[i+1]})
                change = rem[i];
        end
        // bad card or first snack already too expensive
        if (!in_data.card_ok || (in_data.money < {1'b0, in_data.costs[0]}))
            change = in_data.money;
    end

    always_comb begin
        next_data.card_ok = in_data.card_ok;
        next_data.change  = change;
    end

    // ====================
    // slot
    // ====================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

//--- verilog/ssc.sv
/*
 * snack shopping calculator top level
 * three registered stages chained by valid/ready links
 */

`timescale 1ns/1ns

module ssc (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  ssc_pkg::order_t  in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output ssc_pkg::result_t out_data
);

    import ssc_pkg::*;

    // stage 1 to stage 2, costs unsorted
    logic    eval_valid;
    logic    eval_ready;
    priced_t eval_data;

    // stage 2 to stage 3, costs[0] largest
    logic    sort_valid;
    logic    sort_ready;
    priced_t sort_data;

    // card check and costs
    order_eval i_order_eval (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (eval_valid),
        .out_ready (eval_ready),
        .out_data  (eval_data)
    );

    // descending sort
    sort_network i_sort_network (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (eval_valid),
        .in_ready  (eval_ready),
        .in_data   (eval_data),
        .out_valid (sort_valid),
        .out_ready (sort_ready),
        .out_data  (sort_data)
    );

    // greedy change
    change_calc i_change_calc (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sort_valid),
        .in_ready  (sort_ready),
        .in_data   (sort_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

//--- testbench/tb_ssc.sv
/*
 * testbench for the snack calculator pipeline
 * order generator, reference model, scoreboard and handshake checks
 */

`timescale 1ns/1ns

module tb_ssc;

    import ssc_pkg::*;

    // orders per test
    localparam int n_reject  = 100;
    localparam int n_partial = 200;
    localparam int n_full    = 50;
    localparam int n_stream  = 100;
    localparam int n_stall   = 150;
    localparam int n_orders  = n_reject + n_partial + n_full + n_stream + n_stall;
    // about two cycles per stalled order plus reset and drains
    localparam int timeout_cycles = 5 * n_orders;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    order_t  in_data;
    logic    out_valid;
    logic    out_ready;
    result_t out_data;

    int      cycle;
    int      checks;
    int      errors;
    int      tests;
    bit      stall_mode;
    bit      latency_mode;
    // scoreboard of expected results and their accept cycles
    result_t exp_q[$];
    int      acc_q[$];
    // output held under back-pressure
    bit      hold_valid;
    result_t held_data;

    ssc i_ssc (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ====================
    // reference model
    // ====================

    // even positions from the MS end are doubled
    function automatic int luhn_total(input card_u c);
        int s;
        int d;
        s = 0;
        for (int j = 0; j < n_digits; j++) begin
            d = c.digits[n_digits-1-j];
            if (j % 2 == 0) begin
                d = d * 2;
                if (d >= 10)
                    d = d - 9;
            end
            s = s + d;
        end
        return s;
    endfunction

    function automatic bit luhn_ok(input int s);
        return (s % 10 == 0) && (s >= 50) && (s <= 120);
    endfunction

    function automatic result_t expected_result(input order_t o);
        int      cost [n_items];
        int      tmp;
        int      rem;
        bit      stop;
        result_t r;
        for (int i = 0; i < n_items; i++)
            cost[i] = int'(o.counts[i]) * int'(o.prices[i]);
        // descending insertion sort
        for (int i = 1; i < n_items; i++)
            for (int j = i; j > 0 && cost[j] > cost[j-1]; j--) begin
                tmp       = cost[j];
                cost[j]   = cost[j-1];
                cost[j-1] = tmp;
            end
        // greedy purchase stops at the first unaffordable cost
        rem  = o.money;
        stop = 1'b0;
        for (int i = 0; i < n_items; i++) begin
            if (!stop && rem >= cost[i])
                rem = rem - cost[i];
            else
                stop = 1'b1;
        end
        r.card_ok = luhn_ok(luhn_total(o.card));
        r.change  = r.card_ok ? money_t'(rem) : o.money;
        return r;
    endfunction

    // ====================
    // stimulus helpers
    // ====================

    // kind 0 accepted, 1 sum not a multiple of ten, 2 multiple of ten outside window
    function automatic card_u make_card(input int kind);
        card_u c;
        int    s;
        int    lo;
        int    span;
        int    tries;
        bit    done;
        c     = '0;
        done  = 1'b0;
        tries = 0;
        while (!done && tries < 1000) begin
            tries++;
            lo   = 0;
            span = 10;
            if (kind == 2) begin
                // small digits land below 50, large ones above 120
                lo   = ($urandom % 2) ? 8 : 0;
                span = (lo == 8) ? 2 : 3;
            end
            for (int k = 0; k < n_digits; k++)
                c.digits[k] = digit_t'(lo + $urandom % span);
            // last digit is plain, so it sets the sum mod 10
            if (kind != 1) begin
                c.digits[0] = 4'd0;
                s           = luhn_total(c);
                c.digits[0] = digit_t'((10 - s % 10) % 10);
            end
            s = luhn_total(c);
            case (kind)
                0:       done = luhn_ok(s);
                1:       done = (s % 10 != 0);
                default: done = (s % 10 == 0) && (s < 50 || s > 120);
            endcase
        end
        return c;
    endfunction

    // money mode 0 random, 1 below the largest cost, 2 full purse with small costs
    function automatic order_t random_order(input int card_kind, input int money_mode);
        order_t o;
        int     top;
        o.card = make_card(card_kind);
        top    = 0;
        for (int k = 0; k < n_items; k++) begin
            o.counts[k] = (money_mode == 2) ? 4'($urandom % 4) : 4'($urandom % 16);
            o.prices[k] = (money_mode == 2) ? 4'($urandom % 4) : 4'($urandom % 16);
            if (int'(o.counts[k]) * int'(o.prices[k]) > top)
                top = int'(o.counts[k]) * int'(o.prices[k]);
        end
        o.money = (money_mode == 2) ? 9'd511 : 9'($urandom % 512);
        if (money_mode == 1 && top > 0)
            o.money = 9'($urandom % top);
        return o;
    endfunction

    task automatic check_eq(input string sig, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s expected %0d, actual %0d", $time, sig, exp, act);
            errors++;
        end
    endtask

    // called on a rising edge and returns on the edge of the transfer
    task automatic send_order(input order_t o, input bit strict);
        logic acc;
        int   when;
        in_valid <= 1'b1;
        in_data  <= o;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc  = in_ready;
            when = cycle + 1;
            if (strict)
                check_eq("in_ready", 1, in_ready);
            @(posedge clk);
        end
        exp_q.push_back(expected_result(o));
        acc_q.push_back(when);
    endtask

    task automatic finish_test(input string name, input int base);
        in_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        tests++;
        $display("test %-16s done, %0d errors", name, errors - base);
        @(posedge clk);
    endtask

    // ====================
    // clock-side blocks
    // ====================

    always @(posedge clk) begin
        cycle <= cycle + 1;
        out_ready <= stall_mode ? 1'($urandom % 2) : 1'b1;
    end

    always @(posedge clk) begin
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles, %0d results missing", cycle, exp_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    // scoreboard and stability checks sampled mid-cycle
    always @(negedge clk) begin : check_outputs
        result_t exp;
        int      acc;
        if (rst_n) begin
            if (hold_valid) begin
                check_eq("out_valid", 1, out_valid);
                check_eq("out_data", held_data, out_data);
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected result at %0t ns with no order outstanding", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    check_eq("out_data.card_ok", exp.card_ok, out_data.card_ok);
                    check_eq("out_data.change", exp.change, out_data.change);
                    // the result leaves on the next rising edge
                    if (latency_mode)
                        check_eq("latency", 3, cycle + 1 - acc);
                end
            end
            hold_valid = out_valid && !out_ready;
            held_data  = out_data;
        end
    end

    // ====================
    // test sequence
    // ====================

    initial begin
        int base;
        void'($urandom(32'h76a49494));
        cycle        = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        hold_valid   = 1'b0;
        stall_mode   <= 1'b0;
        latency_mode <= 1'b0;
        rst_n        <= 1'b0;
        in_valid     <= 1'b0;
        in_data      <= '0;
        out_ready    <= 1'b1;

        // reset state
        base = errors;
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            if (k == 9)
                rst_n <= 1'b1;
            @(negedge clk);
            check_eq("out_valid", 0, out_valid);
        end
        @(posedge clk);
        @(negedge clk);
        check_eq("out_valid", 0, out_valid);
        check_eq("in_ready", 1, in_ready);
        @(posedge clk);
        finish_test("reset_state", base);

        // both kinds of rejected card
        base = errors;
        for (int k = 0; k < n_reject; k++)
            send_order(random_order(k % 2 + 1, 0), 1'b0);
        finish_test("rejected_cards", base);

        // odd orders cannot afford the largest cost
        base = errors;
        for (int k = 0; k < n_partial; k++)
            send_order(random_order(0, k % 2), 1'b0);
        finish_test("partial_purchase", base);

        base = errors;
        for (int k = 0; k < n_full; k++)
            send_order(random_order(0, 2), 1'b0);
        finish_test("all_affordable", base);

        // back-to-back orders with a fixed three-cycle latency
        base = errors;
        latency_mode <= 1'b1;
        for (int k = 0; k < n_stream; k++)
            send_order(random_order(k % 3, k % 3 == 0 ? 0 : k % 2), 1'b1);
        finish_test("latency", base);
        latency_mode <= 1'b0;

        base = errors;
        stall_mode <= 1'b1;
        for (int k = 0; k < n_stall; k++)
            send_order(random_order(k % 3, k % 2), 1'b0);
        finish_test("back_pressure", base);
        stall_mode <= 1'b0;

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- compile.f
common/ssc_pkg.sv
verilog/card_checker.sv
verilog/snack_cost.sv
verilog/order_eval.sv
sort/sort_network.sv
verilog/change_calc.sv
verilog/ssc.sv
testbench/tb_ssc.sv
